/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dnc_write_weighting_tb
FILELIST  := dnc_write_weighting.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/dnc_pkg.sv */
//////////////////////////////////////////////////
// Widths, Q1.15 constants, channel structs and
// controller state type for the write weighting
//////////////////////////////////////////////////

package dnc_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // One Q1.15 word
  localparam int FRAC_W = 16;

  // Fraction bits, product shift amount
  localparam int FRAC_SHIFT = FRAC_W - 1;

  // Full width of a word by word product
  localparam int PROD_W = 2 * FRAC_W;

  // Longest vector per command
  localparam int MAX_N = 256;

  // Counter must hold MAX_N itself
  localparam int CNT_W = $clog2(MAX_N + 1);

  //////////////////////////////////////////////////
  // Fixed point
  //////////////////////////////////////////////////

  // Unsigned Q1.15 value
  typedef logic [FRAC_W-1:0] frac_t;

  // 1.0 in Q1.15
  localparam frac_t FRAC_ONE = frac_t'(32768);

  //////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////

  // Command word, vector length and both gates
  typedef struct packed {
    logic [CNT_W-1:0] size_n;
    frac_t            ga;
    frac_t            gw;
  } ww_cmd_t;

  // Input pair, allocation and content weighting
  typedef struct packed {
    frac_t a;
    frac_t c;
  } ww_elem_t;

  // Result word, last marks element N-1
  typedef struct packed {
    frac_t w;
    logic  last;
  } ww_out_t;

  //////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_DONE,
    S_RELEASE
  } ww_state_t;

endpackage

/* dnc_write_weighting.f */
common/dnc_pkg.sv
rtl/write_weighting/write_weighting_ctrl.sv
rtl/write_weighting/gate_blend.sv
rtl/write_weighting/gate_scale.sv
rtl/dnc_write_weighting.sv
sim/dnc_write_weighting_checker.sv
sim/dnc_write_weighting_tb.sv

/* rtl/dnc_write_weighting.sv */
//////////////////////////////////////////////////
// Write weighting top, controller plus blend
// and scale stages
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dnc_write_weighting
  import dnc_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,

  // Command channel
  input  logic     cmd_req,
  output logic     cmd_ack,
  input  ww_cmd_t  cmd,

  // Input channel
  input  logic     in_req,
  output logic     in_ack,
  input  ww_elem_t in_elem,

  // Output channel
  output logic     out_req,
  input  logic     out_ack,
  output ww_out_t  out_elem
);

  //////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////

  logic  load_blend;
  logic  load_scale;
  logic  last_tag;
  frac_t ga;
  frac_t gw;
  frac_t blend;

  //////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////

  write_weighting_ctrl u_ctrl (
    .CLK        (CLK),
    .RST        (RST),
    .cmd_req    (cmd_req),
    .cmd_ack    (cmd_ack),
    .cmd        (cmd),
    .in_req     (in_req),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .load_blend (load_blend),
    .load_scale (load_scale),
    .last_tag   (last_tag),
    .ga         (ga),
    .gw         (gw)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Stage 1, allocation gate blend
  gate_blend u_blend (
    .CLK   (CLK),
    .RST   (RST),
    .load  (load_blend),
    .elem  (in_elem),
    .ga    (ga),
    .blend (blend)
  );

  // Stage 2, write gate scaling
  gate_scale u_scale (
    .CLK      (CLK),
    .RST      (RST),
    .load     (load_scale),
    .blend    (blend),
    .gw       (gw),
    .last_tag (last_tag),
    .out_elem (out_elem)
  );

endmodule

/* rtl/write_weighting/gate_blend.sv */
//////////////////////////////////////////////////
// Blend stage, ga*a + (1-ga)*c in Q1.15
//////////////////////////////////////////////////

`timescale 1ns/1ps

module gate_blend
  import dnc_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,

  // Load enable from the controller
  input  logic     load,

  // Element and allocation gate
  input  ww_elem_t elem,
  input  frac_t    ga,

  // Registered blend result
  output frac_t    blend
);

  //////////////////////////////////////////////////
  // Arithmetic
  //////////////////////////////////////////////////

  frac_t             ga_inv;
  logic [PROD_W-1:0] prod_a;
  logic [PROD_W-1:0] prod_c;
  logic [PROD_W:0]   prod_sum;

  // 1 - ga, reaches FRAC_ONE for ga of zero
  assign ga_inv = FRAC_ONE - ga;

  // Full width products
  assign prod_a = PROD_W'(ga) * PROD_W'(elem.a);
  assign prod_c = PROD_W'(ga_inv) * PROD_W'(elem.c);

  // Extra bit keeps the sum exact
  assign prod_sum = {1'b0, prod_a} + {1'b0, prod_c};

  //////////////////////////////////////////////////
  // Register
  //////////////////////////////////////////////////

  // Truncate by dropping the low 15 bits
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      blend <= '0;
    end else if (load) begin
      blend <= prod_sum[FRAC_SHIFT +: FRAC_W];
    end
  end

endmodule

/* rtl/write_weighting/gate_scale.sv */
//////////////////////////////////////////////////
// Scale stage, write gate product and last flag
//////////////////////////////////////////////////

`timescale 1ns/1ps

module gate_scale
  import dnc_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,

  // Load enable from the controller
  input  logic    load,

  // Blend result and write gate
  input  frac_t   blend,
  input  frac_t   gw,

  // Marks element N-1
  input  logic    last_tag,

  // Held result, straight to the output port
  output ww_out_t out_elem
);

  //////////////////////////////////////////////////
  // Arithmetic
  //////////////////////////////////////////////////

  logic [PROD_W-1:0] prod_w;

  // gw * blend, full width
  assign prod_w = PROD_W'(gw) * PROD_W'(blend);

  //////////////////////////////////////////////////
  // Register
  //////////////////////////////////////////////////

  // Stays put while the output handshake waits
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_elem.w    <= '0;
      out_elem.last <= 1'b0;
    end else if (load) begin
      // Truncated Q1.15 product
      out_elem.w    <= prod_w[FRAC_SHIFT +: FRAC_W];
      out_elem.last <= last_tag;
    end
  end

endmodule

/* rtl/write_weighting/write_weighting_ctrl.sv */
//////////////////////////////////////////////////
// Write weighting controller, command latch, FSM,
// four-phase channels and stage valid tracking
//////////////////////////////////////////////////

`timescale 1ns/1ps

module write_weighting_ctrl
  import dnc_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,

  // Command channel
  input  logic    cmd_req,
  output logic    cmd_ack,
  input  ww_cmd_t cmd,

  // Input channel
  input  logic    in_req,
  output logic    in_ack,

  // Output channel
  output logic    out_req,
  input  logic    out_ack,

  // Datapath control
  output logic    load_blend,
  output logic    load_scale,
  output logic    last_tag,
  output frac_t   ga,
  output frac_t   gw
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ww_state_t        state;
  ww_cmd_t          cmd_q;

  // Accepted and delivered element counts
  logic [CNT_W-1:0] acc_cnt;
  logic [CNT_W-1:0] dlv_cnt;
  logic [CNT_W-1:0] last_idx;

  // One valid bit per stage
  logic             blend_vld;
  logic             blend_last;
  logic             scale_vld;

  logic             cmd_start;
  logic             in_open;
  logic             out_free;
  logic             final_dlv;

  //////////////////////////////////////////////////
  // Decisions
  //////////////////////////////////////////////////

  // New command seen while idle
  assign cmd_start = (state == S_IDLE) && cmd_req;

  // Index of the final element
  assign last_idx = cmd_q.size_n - CNT_W'(1);

  // Fresh input request, elements still owed
  assign in_open = (state == S_RUN) && in_req && !in_ack &&
                   (acc_cnt < cmd_q.size_n);

  // Output handshake finished, out_ack back low
  assign out_free = scale_vld && !out_req && !out_ack;

  // Scale stage takes the blend result once it is empty
  // or its previous result has been handed over
  assign load_scale = blend_vld && (!scale_vld || out_free);

  // Blend refills while its contents move on, so two
  // elements can be in flight under back-pressure
  assign load_blend = in_open && (!blend_vld || load_scale);

  // Final delivery closes the vector
  assign final_dlv = out_free && (dlv_cnt == last_idx);

  // Latched gates feed the stages
  assign ga       = cmd_q.ga;
  assign gw       = cmd_q.gw;
  assign last_tag = blend_last;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= S_IDLE;
      cmd_q   <= '0;
      cmd_ack <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_req) begin
            cmd_q <= cmd;
            // Empty vector skips straight to the ack
            if (cmd.size_n == '0) begin
              state <= S_DONE;
            end else begin
              state <= S_RUN;
            end
          end
        end
        S_RUN: begin
          if (final_dlv) begin
            state <= S_DONE;
          end
        end
        S_DONE: begin
          cmd_ack <= 1'b1;
          state   <= S_RELEASE;
        end
        S_RELEASE: begin
          // Wait for the host to drop its request
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Element counters
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_cnt <= '0;
      dlv_cnt <= '0;
    end else if (cmd_start) begin
      acc_cnt <= '0;
      dlv_cnt <= '0;
    end else begin
      if (load_blend) begin
        acc_cnt <= acc_cnt + CNT_W'(1);
      end
      if (out_free) begin
        dlv_cnt <= dlv_cnt + CNT_W'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stage valids and channel handshakes
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      blend_vld  <= 1'b0;
      blend_last <= 1'b0;
      scale_vld  <= 1'b0;
      in_ack     <= 1'b0;
      out_req    <= 1'b0;
    end else begin
      // Blend stage, last tag rides with the element
      if (load_blend) begin
        blend_vld  <= 1'b1;
        blend_last <= (acc_cnt == last_idx);
      end else if (load_scale) begin
        blend_vld <= 1'b0;
      end

      // Scale stage stays full until out_ack falls
      if (load_scale) begin
        scale_vld <= 1'b1;
      end else if (out_free) begin
        scale_vld <= 1'b0;
      end

      // in_ack rises with the blend load
      if (load_blend) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0;
      end

      // out_req rises with the scale load, drops on out_ack
      if (load_scale) begin
        out_req <= 1'b1;
      end else if (out_ack) begin
        out_req <= 1'b0;
      end
    end
  end

endmodule

/* sim/dnc_write_weighting_checker.sv */
//////////////////////////////////////////////////
// Handshake assertions, bound to the write
// weighting top
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dnc_write_weighting_checker
  import dnc_pkg::*;
(
  input logic    CLK,
  input logic    RST,
  input logic    cmd_req,
  input logic    cmd_ack,
  input logic    in_req,
  input logic    in_ack,
  input logic    out_req,
  input logic    out_ack,
  input ww_out_t out_elem
);

  // Result held until the sink answers
  assert property (@(posedge CLK) disable iff (RST)
    (out_req && !out_ack) |=> (out_req && $stable(out_elem)))
    else $error("out_req or out_elem changed before out_ack");

  // in_ack only answers a live request
  assert property (@(posedge CLK) disable iff (RST)
    $rose(in_ack) |-> $past(in_req))
    else $error("in_ack rose without in_req");

  // Same for the command channel
  assert property (@(posedge CLK) disable iff (RST)
    $rose(cmd_ack) |-> cmd_req)
    else $error("cmd_ack rose without cmd_req");

endmodule

bind dnc_write_weighting dnc_write_weighting_checker u_checker (
  .CLK      (CLK),
  .RST      (RST),
  .cmd_req  (cmd_req),
  .cmd_ack  (cmd_ack),
  .in_req   (in_req),
  .in_ack   (in_ack),
  .out_req  (out_req),
  .out_ack  (out_ack),
  .out_elem (out_elem)
);

/* sim/dnc_write_weighting_tb.sv */
//////////////////////////////////////////////////
// Write weighting testbench, command table, LCG
// stimulus, reference model and handshake agents
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dnc_write_weighting_tb
  import dnc_pkg::*;
();

  //////////////////////////////////////////////////
  // Constants and types
  //////////////////////////////////////////////////

  localparam int STEP_TIMEOUT = 200;
  localparam int CMD_TIMEOUT  = 20000;

  // Which DUT output a wait watches
  localparam int SEL_CMD_ACK = 0;
  localparam int SEL_IN_ACK  = 1;
  localparam int SEL_OUT_REQ = 2;

  // One command table entry
  typedef struct packed {
    logic [CNT_W-1:0] size_n;
    frac_t            ga;
    frac_t            gw;
    logic             rand_data;  // elements and gates from the LCG
    logic             slow_sink;  // LCG delay before each out_ack
    logic             has_first;
    frac_t            first_w;    // hand-worked w of element 0
  } test_t;

  //////////////////////////////////////////////////
  // DUT and clock
  //////////////////////////////////////////////////

  logic     CLK;
  logic     RST;
  logic     cmd_req;
  logic     cmd_ack;
  ww_cmd_t  cmd;
  logic     in_req;
  logic     in_ack;
  ww_elem_t in_elem;
  logic     out_req;
  logic     out_ack;
  ww_out_t  out_elem;

  dnc_write_weighting uut (
    .CLK      (CLK),
    .RST      (RST),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .cmd      (cmd),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .in_elem  (in_elem),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_elem (out_elem)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Test state
  //////////////////////////////////////////////////

  test_t       tests[$];
  string       names[$];
  test_t       cur;
  string       cur_name;
  frac_t       cur_ga;
  frac_t       cur_gw;
  frac_t       elem_a [MAX_N];
  frac_t       elem_c [MAX_N];
  frac_t       exp_w  [MAX_N];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          timeouts;
  int          done_count;
  logic        timed_out;

  // Running count of out_req rising edges
  int          out_rises = 0;
  logic        out_req_prev = 1'b0;

  always @(negedge CLK) begin
    if (out_req === 1'b1 && out_req_prev !== 1'b1) begin
      out_rises <= out_rises + 1;
    end
    out_req_prev <= out_req;
  end

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // Low bits of an LCG cycle too fast
    return {8'd0, lcg_state[31:8]};
  endfunction

  // Any Q1.15 value from 0 up to 1.0
  function automatic frac_t rand_frac();
    return frac_t'(lcg_next() % 32'd32769);
  endfunction

  // w = gw * (ga*a + (1-ga)*c), each product truncated by 15 bits
  function automatic frac_t ref_weight(input frac_t ga, input frac_t gw,
                                       input frac_t a, input frac_t c);
    logic [63:0] blend;
    logic [63:0] w;
    blend = (64'(ga) * 64'(a) + (64'(FRAC_ONE) - 64'(ga)) * 64'(c)) >> 15;
    w     = (64'(gw) * 64'(blend[15:0])) >> 15;
    return w[15:0];
  endfunction

  //////////////////////////////////////////////////
  // Waits
  //////////////////////////////////////////////////

  function automatic logic sig_value(input int sel);
    case (sel)
      SEL_CMD_ACK: return cmd_ack;
      SEL_IN_ACK:  return in_ack;
      default:     return out_req;
    endcase
  endfunction

  // Samples on the falling edge, away from the driven edge
  task automatic wait_signal(input int sel, input logic level, input int limit,
                             input string what);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (sig_value(sel) !== level && n < limit);
    if (sig_value(sel) !== level) begin
      errors++;
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout in %s: %s not seen within %0d cycles", cur_name, what, limit);
    end
  endtask

  //////////////////////////////////////////////////
  // Command table
  //////////////////////////////////////////////////

  task automatic add_test(input string name, input int n, input int ga, input int gw,
                          input logic rnd, input logic slow, input int first);
    test_t t;
    t.size_n    = CNT_W'(n);
    t.ga        = frac_t'(ga);
    t.gw        = frac_t'(gw);
    t.rand_data = rnd;
    t.slow_sink = slow;
    t.has_first = (first >= 0);
    t.first_w   = frac_t'(first);
    tests.push_back(t);
    names.push_back(name);
  endtask

  task automatic load_table();
    // Directed element 0 is a = 1024, c = 31744
    add_test("ga_one",      8,   32768, 16384, 1'b0, 1'b0, 512);
    add_test("ga_zero",     8,   0,     32768, 1'b0, 1'b0, 31744);
    add_test("gw_one",      8,   10000, 32768, 1'b0, 1'b1, 22369);
    add_test("single",      1,   16384, 32768, 1'b0, 1'b1, 16384);
    add_test("rand_fast",   64,  0,     0,     1'b1, 1'b0, -1);
    add_test("rand_slow",   48,  0,     0,     1'b1, 1'b1, -1);
    add_test("empty",       0,   16384, 16384, 1'b0, 1'b0, -1);
    add_test("after_empty", 16,  0,     0,     1'b1, 1'b1, -1);
    add_test("full_len",    256, 0,     0,     1'b1, 1'b1, -1);
  endtask

  //////////////////////////////////////////////////
  // Channel agents
  //////////////////////////////////////////////////

  task automatic prepare_test(input int n);
    if (cur.rand_data) begin
      cur_ga = rand_frac();
      cur_gw = rand_frac();
    end else begin
      cur_ga = cur.ga;
      cur_gw = cur.gw;
    end
    for (int j = 0; j < n; j++) begin
      if (cur.rand_data) begin
        elem_a[j] = rand_frac();
        elem_c[j] = rand_frac();
      end else begin
        // Ramp on a, c fills up to 1.0
        elem_a[j] = frac_t'(1024 * (j + 1));
        elem_c[j] = FRAC_ONE - elem_a[j];
      end
      exp_w[j] = ref_weight(cur_ga, cur_gw, elem_a[j], elem_c[j]);
    end
  endtask

  task automatic drive_command(input int n);
    @(posedge CLK);
    cmd.size_n <= cur.size_n;
    cmd.ga     <= cur_ga;
    cmd.gw     <= cur_gw;
    cmd_req    <= 1'b1;
    wait_signal(SEL_CMD_ACK, 1'b1, CMD_TIMEOUT, "cmd_ack rise");
    // Every output handshake is over before the ack
    checks++;
    if (done_count != n) begin
      errors++;
      $display("Error %s: handshakes before cmd_ack expected %0d actual %0d",
               cur_name, n, done_count);
    end
    @(posedge CLK);
    cmd_req <= 1'b0;
    wait_signal(SEL_CMD_ACK, 1'b0, STEP_TIMEOUT, "cmd_ack fall");
  endtask

  task automatic feed_inputs(input int n);
    for (int j = 0; j < n; j++) begin
      @(posedge CLK);
      in_elem.a <= elem_a[j];
      in_elem.c <= elem_c[j];
      in_req    <= 1'b1;
      wait_signal(SEL_IN_ACK, 1'b1, STEP_TIMEOUT, "in_ack rise");
      @(posedge CLK);
      in_req <= 1'b0;
      wait_signal(SEL_IN_ACK, 1'b0, STEP_TIMEOUT, "in_ack fall");
      if (timed_out) break;
    end
  endtask

  task automatic collect_outputs(input int n);
    int delay;
    for (int k = 0; k < n; k++) begin
      wait_signal(SEL_OUT_REQ, 1'b1, STEP_TIMEOUT, "out_req rise");
      if (timed_out) break;
      checks++;
      if (out_elem.w !== exp_w[k]) begin
        errors++;
        $display("Error %s: w of element %0d expected %0d actual %0d",
                 cur_name, k, exp_w[k], out_elem.w);
      end
      checks++;
      if (out_elem.last !== (k == n - 1)) begin
        errors++;
        $display("Error %s: last flag of element %0d expected %0d actual %0d",
                 cur_name, k, (k == n - 1), out_elem.last);
      end
      if (k == 0 && cur.has_first) begin
        checks++;
        if (out_elem.w !== cur.first_w) begin
          errors++;
          $display("Error %s: hand-worked w of element 0 expected %0d actual %0d",
                   cur_name, cur.first_w, out_elem.w);
        end
      end
      // Back-pressure, hold off the ack for a while
      delay = 0;
      if (cur.slow_sink) begin
        delay = int'(lcg_next() % 32'd8);
      end
      repeat (delay) @(posedge CLK);
      @(posedge CLK);
      out_ack <= 1'b1;
      wait_signal(SEL_OUT_REQ, 1'b0, STEP_TIMEOUT, "out_req fall");
      @(posedge CLK);
      out_ack <= 1'b0;
      done_count++;
    end
  endtask

  task automatic run_test(input int idx);
    int n;
    int rise_start;
    cur        = tests[idx];
    cur_name   = names[idx];
    n          = int'(cur.size_n);
    prepare_test(n);
    rise_start = out_rises;
    done_count = 0;
    fork
      drive_command(n);
      feed_inputs(n);
      collect_outputs(n);
    join
    // Exactly N results, none for an empty vector
    checks++;
    if (out_rises - rise_start != n) begin
      errors++;
      $display("Error %s: out_req count expected %0d actual %0d",
               cur_name, n, out_rises - rise_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    RST     <= 1'b1;
    cmd_req <= 1'b0;
    cmd     <= '0;
    in_req  <= 1'b0;
    in_elem <= '0;
    out_ack <= 1'b0;
    lcg_state = 32'd37;
    errors    = 0;
    checks    = 0;
    timeouts  = 0;
    timed_out = 1'b0;
    cur_name  = "reset";
    load_table();

    repeat (8) @(posedge CLK);
    RST <= 1'b0;
    @(negedge CLK);

    // Quiet channels before any command
    checks++;
    if (cmd_ack !== 1'b0 || in_ack !== 1'b0 || out_req !== 1'b0) begin
      errors++;
      $display("Error reset: cmd_ack in_ack out_req expected 000 actual %b%b%b",
               cmd_ack, in_ack, out_req);
    end

    for (int i = 0; i < tests.size(); i++) begin
      run_test(i);
    end

    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
